// ==== hdl/fir_pkg.sv ====
package fir_pkg;

    localparam int DATA_W = 32;
    localparam int ADDR_W = 12;

    typedef logic signed [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0]        addr_t;

    localparam data_t DATA_MAX = {1'b0, {(DATA_W-1){1'b1}}};
    localparam data_t DATA_MIN = {1'b1, {(DATA_W-1){1'b0}}};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam addr_t REG_AP_CTRL  = 12'h000;
    localparam addr_t REG_DATA_LEN = 12'h010;
    // Tap k at TAP_BASE + 4*k
    localparam addr_t TAP_BASE     = 12'h020;

    typedef struct packed {
        logic ap_idle;
        logic ap_done;
        logic ap_start;
    } ap_status_t;

    typedef struct packed {
        data_t data;
        logic  last;
    } sample_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_COMMIT
    } axil_wr_state_e;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_RESP
    } axil_rd_state_e;

    typedef enum logic [1:0] {
        MAC_IDLE,
        MAC_ACCUM,
        MAC_HOLD
    } mac_state_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Saturating arithmetic
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic data_t sat_mul(data_t a, data_t b);
        logic signed [2*DATA_W-1:0] prod;
        prod = a * b;
        if (prod > DATA_MAX) begin
            return DATA_MAX;
        end else if (prod < DATA_MIN) begin
            return DATA_MIN;
        end
        return prod[DATA_W-1:0];
    endfunction

    function automatic data_t sat_add(data_t a, data_t b);
        logic signed [DATA_W:0] sum;
        sum = a + b;
        // One extra bit is enough to see the wrap
        if (sum > DATA_MAX) begin
            return DATA_MAX;
        end else if (sum < DATA_MIN) begin
            return DATA_MIN;
        end
        return sum[DATA_W-1:0];
    endfunction

endpackage

// ==== hdl/fir_cfg_regs.sv ====
module fir_cfg_regs
    import fir_pkg::*;
#(
    parameter int num_taps = 11
) (
    input  logic  axis_clk,
    input  logic  axis_rst_n,
    input  logic  awvalid,
    input  addr_t awaddr,
    output logic  awready,
    input  logic  wvalid,
    input  data_t wdata,
    output logic  wready,
    input  logic  arvalid,
    input  addr_t araddr,
    output logic  arready,
    input  logic  rready,
    output logic  rvalid,
    output data_t rdata,
    input  logic  sample_fire,
    input  logic  run_done,
    output logic  running,
    output data_t taps [num_taps]
);

    localparam int IDX_W = ADDR_W - 2;

    axil_wr_state_e      wr_state;
    axil_rd_state_e      rd_state;
    addr_t               wr_addr;
    addr_t               wr_off;
    addr_t               rd_off;
    logic [IDX_W-1:0]    wr_idx;
    logic [IDX_W-1:0]    rd_idx;
    logic                wr_tap_hit;
    logic                rd_tap_hit;
    logic                wr_ctrl;
    logic                rd_capture;
    logic                start_ok;
    ap_status_t          ap_status;
    data_t               data_len;
    logic                len_written;
    logic [num_taps-1:0] tap_written;
    data_t               tap_rd;
    data_t               rd_value;

    assign running    = !ap_status.ap_idle;
    assign start_ok   = len_written && (&tap_written);
    assign wr_ctrl    = (wr_state == WR_COMMIT) && !running;
    assign rd_capture = (rd_state == RD_ADDR);

    assign awready = (wr_state == WR_ADDR);
    assign wready  = (wr_state == WR_COMMIT);
    assign arready = (rd_state == RD_ADDR);
    assign rvalid  = (rd_state == RD_RESP);

    // Tap slot decode
    assign wr_off     = wr_addr - TAP_BASE;
    assign rd_off     = araddr - TAP_BASE;
    assign wr_idx     = wr_off[ADDR_W-1:2];
    assign rd_idx     = rd_off[ADDR_W-1:2];
    assign wr_tap_hit = (wr_addr >= TAP_BASE) && (wr_off[1:0] == 2'b00)
                        && (wr_idx < IDX_W'(num_taps));
    assign rd_tap_hit = (araddr >= TAP_BASE) && (rd_off[1:0] == 2'b00)
                        && (rd_idx < IDX_W'(num_taps));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // AXI-Lite channel FSMs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            wr_state <= WR_IDLE;
            rd_state <= RD_IDLE;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    if (awvalid) begin
                        wr_state <= WR_ADDR;
                    end
                end
                WR_ADDR: wr_state <= WR_DATA;
                WR_DATA: begin
                    if (wvalid) begin
                        wr_state <= WR_COMMIT;
                    end
                end
                default: wr_state <= WR_IDLE;
            endcase

            case (rd_state)
                RD_IDLE: begin
                    if (arvalid) begin
                        rd_state <= RD_ADDR;
                    end
                end
                RD_ADDR: rd_state <= RD_RESP;
                RD_RESP: begin
                    if (rready) begin
                        rd_state <= RD_IDLE;
                    end
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    always_comb begin
        tap_rd = '1;
        for (int k = 0; k < num_taps; k++) begin
            if (rd_idx == IDX_W'(k)) begin
                tap_rd = taps[k];
            end
        end
        rd_value = '1;
        if (araddr == REG_AP_CTRL) begin
            rd_value      = '0;
            rd_value[2:0] = ap_status;
        end else if (araddr == REG_DATA_LEN) begin
            rd_value = data_len;
        end else if (rd_tap_hit) begin
            rd_value = tap_rd;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Run control and written flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            ap_status   <= '{ap_idle: 1'b1, ap_done: 1'b0, ap_start: 1'b0};
            len_written <= 1'b0;
            tap_written <= '0;
        end else begin
            if (wr_ctrl) begin
                if (wr_addr == REG_DATA_LEN) begin
                    len_written <= 1'b1;
                end
                for (int k = 0; k < num_taps; k++) begin
                    if (wr_tap_hit && wr_idx == IDX_W'(k)) begin
                        tap_written[k] <= 1'b1;
                    end
                end
                if (wr_addr == REG_AP_CTRL && wdata[0] && start_ok) begin
                    ap_status.ap_start <= 1'b1;
                    ap_status.ap_idle  <= 1'b0;
                end
            end
            // Start bit drops with the first accepted sample
            if (sample_fire) begin
                ap_status.ap_start <= 1'b0;
            end
            if (rd_capture && araddr == REG_AP_CTRL) begin
                ap_status.ap_done <= 1'b0;
            end
            if (run_done) begin
                ap_status.ap_done <= 1'b1;
                ap_status.ap_idle <= 1'b1;
                len_written       <= 1'b0;
                tap_written       <= '0;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (wr_state == WR_ADDR) begin
            wr_addr <= awaddr;
        end
        if (rd_capture) begin
            rdata <= rd_value;
        end
        if (wr_ctrl && wr_addr == REG_DATA_LEN) begin
            data_len <= wdata;
        end
        for (int k = 0; k < num_taps; k++) begin
            if (wr_ctrl && wr_tap_hit && wr_idx == IDX_W'(k)) begin
                taps[k] <= wdata;
            end
        end
    end

endmodule

// ==== hdl/fir_sample_in.sv ====
module fir_sample_in
    import fir_pkg::*;
#(
    parameter int num_taps = 11
) (
    input  logic  axis_clk,
    input  logic  axis_rst_n,
    input  logic  ss_tvalid,
    input  data_t ss_tdata,
    input  logic  ss_tlast,
    output logic  ss_tready,
    input  logic  running,
    output logic  sample_fire,
    output data_t window [num_taps],
    output logic  window_last,
    output logic  window_valid,
    input  logic  window_ready
);

    // Newest sample at index 0
    data_t hist [num_taps];
    logic  window_full;
    logic  last_seen;

    assign ss_tready    = running && !window_full && !last_seen;
    assign sample_fire  = ss_tvalid && ss_tready;
    assign window_valid = window_full;
    assign window       = hist;

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            window_full <= 1'b0;
            last_seen   <= 1'b0;
        end else begin
            if (window_valid && window_ready) begin
                window_full <= 1'b0;
            end else if (sample_fire) begin
                window_full <= 1'b1;
            end
            // No more input once tlast is in
            if (!running) begin
                last_seen <= 1'b0;
            end else if (sample_fire && ss_tlast) begin
                last_seen <= 1'b1;
            end
        end
    end

    // History doubles as the held window register
    always_ff @(posedge axis_clk) begin
        if (!running) begin
            for (int k = 0; k < num_taps; k++) begin
                hist[k] <= '0;
            end
        end else if (sample_fire) begin
            hist[0] <= ss_tdata;
            for (int k = 1; k < num_taps; k++) begin
                hist[k] <= hist[k-1];
            end
            window_last <= ss_tlast;
        end
    end

endmodule

// ==== hdl/fir_mac_engine.sv ====
module fir_mac_engine
    import fir_pkg::*;
#(
    parameter int num_taps = 11
) (
    input  logic    axis_clk,
    input  logic    axis_rst_n,
    input  data_t   window [num_taps],
    input  logic    window_last,
    input  logic    window_valid,
    output logic    window_ready,
    input  data_t   taps [num_taps],
    output sample_t result,
    output logic    result_valid,
    input  logic    result_ready
);

    localparam int K_W = $clog2(num_taps);

    mac_state_e     state;
    logic [K_W-1:0] k;
    data_t          win [num_taps];
    logic           win_last;
    data_t          acc;

    assign window_ready = (state == MAC_IDLE);
    assign result_valid = (state == MAC_HOLD);
    assign result       = '{data: acc, last: win_last};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sequencing, one tap per cycle
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            state <= MAC_IDLE;
            k     <= '0;
        end else begin
            case (state)
                MAC_IDLE: begin
                    if (window_valid) begin
                        state <= MAC_ACCUM;
                        k     <= '0;
                    end
                end
                MAC_ACCUM: begin
                    k <= k + 1'b1;
                    if (k == K_W'(num_taps - 1)) begin
                        state <= MAC_HOLD;
                    end
                end
                MAC_HOLD: begin
                    // Stall here under output back-pressure
                    if (result_ready) begin
                        state <= MAC_IDLE;
                    end
                end
                default: state <= MAC_IDLE;
            endcase
        end
    end

    // Window copy frees the input register early
    always_ff @(posedge axis_clk) begin
        if (window_valid && window_ready) begin
            win      <= window;
            win_last <= window_last;
            acc      <= '0;
        end else if (state == MAC_ACCUM) begin
            acc <= sat_add(acc, sat_mul(taps[k], win[k]));
        end
    end

endmodule

// ==== hdl/fir_result_out.sv ====
module fir_result_out
    import fir_pkg::*;
(
    input  logic    axis_clk,
    input  logic    axis_rst_n,
    input  sample_t result,
    input  logic    result_valid,
    output logic    result_ready,
    output logic    sm_tvalid,
    output data_t   sm_tdata,
    output logic    sm_tlast,
    input  logic    sm_tready,
    output logic    run_done
);

    sample_t out_q;
    logic    full;

    // Accept when empty or draining this cycle
    assign result_ready = !full || sm_tready;
    assign sm_tvalid    = full;
    assign sm_tdata     = out_q.data;
    assign sm_tlast     = out_q.last;
    assign run_done     = full && sm_tready && out_q.last;

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            full <= 1'b0;
        end else if (result_valid && result_ready) begin
            full <= 1'b1;
        end else if (sm_tready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (result_valid && result_ready) begin
            out_q <= result;
        end
    end

endmodule

// ==== hdl/fir_top.sv ====
module fir_top
    import fir_pkg::*;
#(
    parameter int num_taps = 11
) (
    input  logic  axis_clk,
    input  logic  axis_rst_n,
    input  logic  awvalid,
    input  addr_t awaddr,
    output logic  awready,
    input  logic  wvalid,
    input  data_t wdata,
    output logic  wready,
    input  logic  arvalid,
    input  addr_t araddr,
    output logic  arready,
    input  logic  rready,
    output logic  rvalid,
    output data_t rdata,
    input  logic  ss_tvalid,
    input  data_t ss_tdata,
    input  logic  ss_tlast,
    output logic  ss_tready,
    output logic  sm_tvalid,
    output data_t sm_tdata,
    output logic  sm_tlast,
    input  logic  sm_tready
);

    logic    running;
    logic    sample_fire;
    logic    run_done;
    data_t   taps [num_taps];
    data_t   window [num_taps];
    logic    window_last;
    logic    window_valid;
    logic    window_ready;
    sample_t result;
    logic    result_valid;
    logic    result_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Configuration slave
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    fir_cfg_regs #(
        .num_taps (num_taps)
    ) u_cfg_regs (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .awvalid     (awvalid),
        .awaddr      (awaddr),
        .awready     (awready),
        .wvalid      (wvalid),
        .wdata       (wdata),
        .wready      (wready),
        .arvalid     (arvalid),
        .araddr      (araddr),
        .arready     (arready),
        .rready      (rready),
        .rvalid      (rvalid),
        .rdata       (rdata),
        .sample_fire (sample_fire),
        .run_done    (run_done),
        .running     (running),
        .taps        (taps)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stream datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    fir_sample_in #(
        .num_taps (num_taps)
    ) u_sample_in (
        .axis_clk     (axis_clk),
        .axis_rst_n   (axis_rst_n),
        .ss_tvalid    (ss_tvalid),
        .ss_tdata     (ss_tdata),
        .ss_tlast     (ss_tlast),
        .ss_tready    (ss_tready),
        .running      (running),
        .sample_fire  (sample_fire),
        .window       (window),
        .window_last  (window_last),
        .window_valid (window_valid),
        .window_ready (window_ready)
    );

    fir_mac_engine #(
        .num_taps (num_taps)
    ) u_mac_engine (
        .axis_clk     (axis_clk),
        .axis_rst_n   (axis_rst_n),
        .window       (window),
        .window_last  (window_last),
        .window_valid (window_valid),
        .window_ready (window_ready),
        .taps         (taps),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready)
    );

    fir_result_out u_result_out (
        .axis_clk     (axis_clk),
        .axis_rst_n   (axis_rst_n),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .sm_tvalid    (sm_tvalid),
        .sm_tdata     (sm_tdata),
        .sm_tlast     (sm_tlast),
        .sm_tready    (sm_tready),
        .run_done     (run_done)
    );

endmodule

// ==== sim/fir_assertions.sv ====
module fir_assertions
    import fir_pkg::*;
(
    input logic  axis_clk,
    input logic  axis_rst_n,
    input logic  awready,
    input logic  wready,
    input logic  arready,
    input logic  rvalid,
    input logic  rready,
    input data_t rdata,
    input logic  ss_tvalid,
    input logic  ss_tlast,
    input logic  ss_tready,
    input logic  running,
    input logic  sm_tvalid,
    input logic  sm_tready,
    input data_t sm_tdata,
    input logic  sm_tlast
);

    timeunit 1ns;
    timeprecision 1ps;

    int   fail_count = 0;
    logic input_closed;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Handshake stability
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    sm_stall_stable: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata) && $stable(sm_tlast))
    else begin
        $error("stream output changed or dropped while stalled");
        fail_count++;
    end

    rvalid_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata))
    else begin
        $error("read response dropped or changed before rready");
        fail_count++;
    end

    // Input stays closed from the accepted tlast until the run is idle
    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            input_closed <= 1'b0;
        end else if (ss_tvalid && ss_tready && ss_tlast) begin
            input_closed <= 1'b1;
        end else if (!running) begin
            input_closed <= 1'b0;
        end
    end

    no_input_after_last: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        input_closed |-> !ss_tready)
    else begin
        $error("ss_tready high after the last input sample of the run");
        fail_count++;
    end

    outputs_low_after_reset: assert property (@(posedge axis_clk)
        !axis_rst_n |=> !(awready || wready || arready || rvalid || ss_tready || sm_tvalid))
    else begin
        $error("handshake output high in the cycle after reset");
        fail_count++;
    end

endmodule

bind fir_top fir_assertions u_fir_assertions (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .awready    (awready),
    .wready     (wready),
    .arready    (arready),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata),
    .ss_tvalid  (ss_tvalid),
    .ss_tlast   (ss_tlast),
    .ss_tready  (ss_tready),
    .running    (running),
    .sm_tvalid  (sm_tvalid),
    .sm_tready  (sm_tready),
    .sm_tdata   (sm_tdata),
    .sm_tlast   (sm_tlast)
);

// ==== sim/fir_tb.sv ====
module fir_tb
    import fir_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_taps        = 11;
    localparam int total_samples   = 40 + 20 + 40;
    localparam int watchdog_cycles = total_samples * (num_taps + 6) + 2000;
    localparam longint max_l       = 64'sd2147483647;
    localparam longint min_l       = -64'sd2147483648;

    logic  axis_clk;
    logic  axis_rst_n;
    logic  awvalid;
    addr_t awaddr;
    logic  awready;
    logic  wvalid;
    data_t wdata;
    logic  wready;
    logic  arvalid;
    addr_t araddr;
    logic  arready;
    logic  rready;
    logic  rvalid;
    data_t rdata;
    logic  ss_tvalid;
    data_t ss_tdata;
    logic  ss_tlast;
    logic  ss_tready;
    logic  sm_tvalid;
    data_t sm_tdata;
    logic  sm_tlast;
    logic  sm_tready;

    data_t tap_val [num_taps];
    data_t samples [$];
    data_t hist_q [$];
    data_t exp_data [$];
    logic  exp_last [$];
    logic  bp_on;
    int    errors;
    int    test_num;
    int    tests_failed;
    int    test_start_errs;
    int    seen_max;
    int    seen_min;
    string test_name;

    fir_top #(
        .num_taps (num_taps)
    ) u_fir_top (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .awready    (awready),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .wready     (wready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rready     (rready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tlast   (ss_tlast),
        .ss_tready  (ss_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast),
        .sm_tready  (sm_tready)
    );

    initial begin
        axis_clk = 1'b0;
        forever begin
            #4 axis_clk = ~axis_clk;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Golden model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic data_t clamp(longint v);
        if (v > max_l) begin
            return data_t'(max_l);
        end else if (v < min_l) begin
            return data_t'(min_l);
        end
        return data_t'(v);
    endfunction

    // Taps in order against newest-first history
    function automatic data_t model_output();
        data_t acc;
        data_t term;
        acc = '0;
        for (int k = 0; k < num_taps; k++) begin
            term = clamp(longint'(tap_val[k]) * longint'(hist_q[k]));
            acc  = clamp(longint'(acc) + longint'(term));
        end
        return acc;
    endfunction

    function automatic data_t rand_signed(int bits);
        int span;
        span = 1 << bits;
        return data_t'($urandom_range(span - 1, 0)) - data_t'(span / 2);
    endfunction

    function automatic int error_total();
        return errors + u_fir_top.u_fir_assertions.fail_count;
    endfunction

    task automatic check_value(string name, data_t exp, data_t got);
        assert (got === exp) else begin
            $display("Error at %0d ns: %s expected %h, got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic start_test(string name);
        test_num++;
        test_name       = name;
        test_start_errs = error_total();
    endtask

    task automatic end_test();
        int n;
        n = error_total() - test_start_errs;
        if (n == 0) begin
            $display("Test %0d %s: passed", test_num, test_name);
        end else begin
            $display("Test %0d %s: failed with %0d errors", test_num, test_name, n);
            tests_failed++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // AXI-Lite and stream drivers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic axil_write(addr_t addr, data_t data);
        @(posedge axis_clk);
        awvalid <= 1'b1;
        awaddr  <= addr;
        do begin
            @(negedge axis_clk);
        end while (!awready);
        @(posedge axis_clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b1;
        wdata   <= data;
        do begin
            @(negedge axis_clk);
        end while (!wready);
        @(posedge axis_clk);
        wvalid <= 1'b0;
    endtask

    task automatic axil_read(addr_t addr, output data_t data);
        @(posedge axis_clk);
        arvalid <= 1'b1;
        araddr  <= addr;
        do begin
            @(negedge axis_clk);
        end while (!arready);
        @(posedge axis_clk);
        arvalid <= 1'b0;
        // Late rready keeps rvalid waiting
        repeat ($urandom_range(2, 0)) @(posedge axis_clk);
        rready <= 1'b1;
        do begin
            @(negedge axis_clk);
        end while (!rvalid);
        data = rdata;
        @(posedge axis_clk);
        rready <= 1'b0;
    endtask

    task automatic write_taps(int first, int last);
        for (int k = first; k <= last; k++) begin
            axil_write(TAP_BASE + addr_t'(4 * k), tap_val[k]);
        end
    endtask

    task automatic start_run();
        axil_write(REG_AP_CTRL, data_t'(1));
        hist_q.delete();
        for (int k = 0; k < num_taps; k++) begin
            hist_q.push_back('0);
        end
    endtask

    task automatic configure_run(int len);
        axil_write(REG_DATA_LEN, data_t'(len));
        write_taps(0, num_taps - 1);
        start_run();
    endtask

    task automatic send_stream(int gap_max);
        data_t s;
        for (int i = 0; i < samples.size(); i++) begin
            s = samples[i];
            hist_q.push_front(s);
            void'(hist_q.pop_back());
            exp_data.push_back(model_output());
            exp_last.push_back(i == samples.size() - 1);
            @(posedge axis_clk);
            ss_tvalid <= 1'b1;
            ss_tdata  <= s;
            ss_tlast  <= (i == samples.size() - 1);
            do begin
                @(negedge axis_clk);
            end while (!ss_tready);
            @(posedge axis_clk);
            ss_tvalid <= 1'b0;
            ss_tlast  <= 1'b0;
            repeat ($urandom_range(gap_max, 0)) @(posedge axis_clk);
        end
    endtask

    task automatic wait_drain();
        while (exp_data.size() != 0) begin
            @(posedge axis_clk);
        end
        repeat (2) @(posedge axis_clk);
    endtask

    initial begin
        forever begin
            @(posedge axis_clk);
            if (bp_on) begin
                sm_tready <= ($urandom_range(1, 0) == 1);
            end else begin
                sm_tready <= 1'b1;
            end
        end
    end

    // Handshake completes at the next rising edge
    initial begin
        forever begin
            @(negedge axis_clk);
            if (sm_tvalid && sm_tready) begin
                if (exp_data.size() == 0) begin
                    $display("Output %h at %0d ns arrived with no sample pending", sm_tdata,
                             $time);
                    errors++;
                end else begin
                    check_value("sm_tdata", exp_data.pop_front(), sm_tdata);
                    check_value("sm_tlast", data_t'(exp_last.pop_front()), data_t'(sm_tlast));
                end
                if (sm_tdata == DATA_MAX) begin
                    seen_max++;
                end
                if (sm_tdata == DATA_MIN) begin
                    seen_min++;
                end
            end
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge axis_clk);
        $display("Timeout: the run did not finish within %0d clock cycles", watchdog_cycles);
        $display("** FAIL **");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        data_t rd;
        void'($urandom(32'h9adb));
        axis_rst_n = 1'b0;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        ss_tlast   = 1'b0;
        sm_tready  = 1'b0;
        bp_on      = 1'b0;
        errors     = 0;
        test_num   = 0;
        tests_failed = 0;
        seen_max   = 0;
        seen_min   = 0;
        repeat (16) @(posedge axis_clk);
        axis_rst_n <= 1'b1;
        repeat (2) @(posedge axis_clk);

        start_test("register read-back");
        for (int k = 0; k < num_taps; k++) begin
            tap_val[k] = rand_signed(8);
        end
        axil_write(REG_DATA_LEN, data_t'(40));
        // Last tap held back for the gating test
        write_taps(0, num_taps - 2);
        axil_read(REG_DATA_LEN, rd);
        check_value("data_len", data_t'(40), rd);
        for (int k = 0; k < num_taps - 1; k++) begin
            axil_read(TAP_BASE + addr_t'(4 * k), rd);
            check_value($sformatf("tap[%0d]", k), tap_val[k], rd);
        end
        axil_read(addr_t'(12'h004), rd);
        check_value("rdata at 0x004", data_t'(-1), rd);
        axil_read(addr_t'(12'hffc), rd);
        check_value("rdata at 0xffc", data_t'(-1), rd);
        end_test();

        start_test("start gating");
        axil_write(REG_AP_CTRL, data_t'(1));
        axil_read(REG_AP_CTRL, rd);
        check_value("ap_idle", data_t'(1), data_t'(rd[2]));
        @(negedge axis_clk);
        check_value("ss_tready", data_t'(0), data_t'(ss_tready));
        write_taps(num_taps - 1, num_taps - 1);
        axil_read(TAP_BASE + addr_t'(4 * (num_taps - 1)), rd);
        check_value("last tap", tap_val[num_taps - 1], rd);
        start_run();
        axil_read(REG_AP_CTRL, rd);
        check_value("ap_idle", data_t'(0), data_t'(rd[2]));
        end_test();

        start_test("filtering");
        samples.delete();
        for (int i = 0; i < 40; i++) begin
            samples.push_back(rand_signed(12));
        end
        send_stream(0);
        wait_drain();
        end_test();

        start_test("saturation");
        for (int k = 0; k < num_taps; k++) begin
            tap_val[k] = data_t'(32'h0010_0000);
        end
        samples.delete();
        for (int i = 0; i < 20; i++) begin
            samples.push_back((i < 8) ? data_t'(32'h4000_0000) : data_t'(32'hc000_0000));
        end
        configure_run(20);
        seen_max = 0;
        seen_min = 0;
        send_stream(0);
        wait_drain();
        check_value("outputs at maximum", data_t'(1), data_t'(seen_max > 0));
        check_value("outputs at minimum", data_t'(1), data_t'(seen_min > 0));
        end_test();

        start_test("back-pressure");
        for (int k = 0; k < num_taps; k++) begin
            tap_val[k] = rand_signed(8);
        end
        samples.delete();
        for (int i = 0; i < 40; i++) begin
            samples.push_back(rand_signed(16));
        end
        configure_run(40);
        bp_on = 1'b1;
        send_stream(12);
        wait_drain();
        bp_on = 1'b0;
        end_test();

        start_test("completion");
        axil_read(REG_AP_CTRL, rd);
        check_value("ap_ctrl after run", data_t'(6), rd);
        axil_read(REG_AP_CTRL, rd);
        check_value("ap_ctrl second read", data_t'(4), rd);
        // Flags were cleared by the finished run
        axil_write(REG_AP_CTRL, data_t'(1));
        axil_read(REG_AP_CTRL, rd);
        check_value("ap_ctrl after restart", data_t'(4), rd);
        @(negedge axis_clk);
        check_value("ss_tready", data_t'(0), data_t'(ss_tready));
        end_test();

        $display("Summary: %0d tests run, %0d failed, %0d errors", test_num, tests_failed,
                 error_total());
        if (error_total() == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
hdl/fir_pkg.sv
hdl/fir_cfg_regs.sv
hdl/fir_sample_in.sv
hdl/fir_mac_engine.sv
hdl/fir_result_out.sv
hdl/fir_top.sv
sim/fir_assertions.sv
sim/fir_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the FIR testbench with Verilator, then search the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal --top-module fir_tb -f sim.f \
    && ./obj_dir/Vfir_tb +verilator+error+limit+1000 > sim.log 2>&1 \
    || { echo "Build or simulation run returned an error" >> sim.log; cat sim.log; exit 1; }

cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && exit 1
exit 0
